/* hdl/cachePkg.sv */
package cachePkg;

  // line geometry of 32-byte lines holding four 64-bit words
  localparam int LineBytes    = 32;
  localparam int WordsPerLine = 4;

  // byte offset within a line and the word select taken from it
  localparam int OffsetBits   = 5;
  localparam int WordSelBits  = 2;

  // controller states
  typedef enum logic [2:0] {
    Idle    = 3'd0,
    Compare = 3'd1,
    Miss    = 3'd2,
    GetData = 3'd3,
    Replay  = 3'd4
  } ctrlState_e;

  // request held from acceptance until its response
  typedef struct packed {
    logic        valid;
    logic [31:0] addr;
  } cacheReq_t;

endpackage

/* hdl/busPkg.sv */
package busPkg;

  // line fetch toward memory
  // valid for a single cycle
  typedef struct packed {
    logic        valid;
    logic [31:0] addr;
  } refillReq_t;

  // one returned word of a line fetch
  // last rides with the final word
  typedef struct packed {
    logic        valid;
    logic        last;
    logic [63:0] data;
  } refillBeat_t;

endpackage

/* hdl/cacheTagArray.sv */
`timescale 1ns/100ps

module cacheTagArray #(
  parameter int IndexBits = 6
) (
  input  logic                 clk,
  input  logic                 rst_n,
  input  logic                 rdEn_i,
  input  logic [IndexBits-1:0] rdIndex_i,
  input  logic [31-IndexBits-$clog2(cachePkg::LineBytes):0] lookupTag_i,
  input  logic                 fillEn_i,
  input  logic                 fillWay_i,
  input  logic [IndexBits-1:0] fillIndex_i,
  input  logic                 touchEn_i,
  output logic                 hit_o,
  output logic                 hitWay_o,
  output logic                 victimWay_o
);

  localparam int NumSets = 1 << IndexBits;
  localparam int TagBits = 32 - IndexBits - $clog2(cachePkg::LineBytes);

  // tags for both ways of every set
  logic [1:0][TagBits-1:0] tagMem [NumSets];

  // valid bits and the least recently used way per set
  logic [NumSets-1:0][1:0] validQ;
  logic [NumSets-1:0]      lruQ;

  // set read at acceptance or replay
  logic [1:0][TagBits-1:0] tagRdQ;
  logic [1:0]              validRdQ;
  logic [1:0]              wayHit;

  always_ff @(posedge clk) begin
    if (fillEn_i) begin
      tagMem[fillIndex_i][fillWay_i] <= lookupTag_i;
    end
    if (rdEn_i) begin
      tagRdQ <= tagMem[rdIndex_i];
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      validQ   <= '0;
      lruQ     <= '0;
      validRdQ <= '0;
    end else begin
      if (rdEn_i) begin
        validRdQ <= validQ[rdIndex_i];
      end
      // the other way becomes the older one
      if (fillEn_i) begin
        validQ[fillIndex_i][fillWay_i] <= 1'b1;
        lruQ[fillIndex_i]              <= ~fillWay_i;
      end else if (touchEn_i) begin
        lruQ[fillIndex_i] <= ~fillWay_i;
      end
    end
  end

  assign wayHit[0] = validRdQ[0] && (tagRdQ[0] == lookupTag_i);
  assign wayHit[1] = validRdQ[1] && (tagRdQ[1] == lookupTag_i);

  assign hit_o    = |wayHit;
  assign hitWay_o = wayHit[1];

  // empty way first, else the older one
  always_comb begin
    if (!validRdQ[0]) begin
      victimWay_o = 1'b0;
    end else if (!validRdQ[1]) begin
      victimWay_o = 1'b1;
    end else begin
      victimWay_o = lruQ[fillIndex_i];
    end
  end

endmodule

/* hdl/cacheDataArray.sv */
`timescale 1ns/100ps

module cacheDataArray #(
  parameter int IndexBits = 6
) (
  input  logic                               clk,
  input  logic                               rst_n,
  input  logic                               rdEn_i,
  input  logic [IndexBits-1:0]               rdIndex_i,
  input  logic                               hitWay_i,
  input  logic [cachePkg::WordSelBits-1:0]   wordSel_i,
  input  busPkg::refillBeat_t                beat_i,
  input  logic                               fillWay_i,
  input  logic [IndexBits-1:0]               fillIndex_i,
  input  logic [cachePkg::WordSelBits-1:0]   fillWord_i,
  output logic [63:0]                        rdWord_o
);

  localparam int NumSets  = 1 << IndexBits;
  localparam int LineBits = cachePkg::LineBytes * 8;
  localparam int WordBits = LineBits / cachePkg::WordsPerLine;

  // whole lines, indexed by set then way
  logic [LineBits-1:0] lineMem [NumSets][2];

  logic [1:0][LineBits-1:0] lineRdQ;
  logic [LineBits-1:0]      hitLine;

  // one word per refill beat into the victim way
  always_ff @(posedge clk) begin
    if (beat_i.valid) begin
      lineMem[fillIndex_i][fillWay_i][fillWord_i*WordBits +: WordBits] <= beat_i.data;
    end
  end

  // both ways read together and the way picked after the tag compare
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      lineRdQ <= '0;
    end else if (rdEn_i) begin
      lineRdQ[0] <= lineMem[rdIndex_i][0];
      lineRdQ[1] <= lineMem[rdIndex_i][1];
    end
  end

  assign hitLine  = lineRdQ[hitWay_i];
  assign rdWord_o = hitLine[wordSel_i*WordBits +: WordBits];

endmodule

/* hdl/cacheCtrl.sv */
`timescale 1ns/100ps

module cacheCtrl #(
  parameter int IndexBits = 6
) (
  input  logic                             clk,
  input  logic                             rst_n,
  // load pipeline
  input  logic [31:0]                      addr_i,
  input  logic                             valid_i,
  output logic                             addrOk_o,
  output logic                             dataOk_o,
  output logic [63:0]                      rdData_o,
  // memory side
  output busPkg::refillReq_t               memReq_o,
  input  busPkg::refillBeat_t              beat_i,
  // from the arrays
  input  logic                             hit_i,
  input  logic                             hitWay_i,
  input  logic                             victimWay_i,
  input  logic [63:0]                      rdWord_i,
  // to the arrays
  output logic                             rdEn_o,
  output logic [IndexBits-1:0]             rdIndex_o,
  output logic [31-IndexBits-cachePkg::OffsetBits:0] lookupTag_o,
  output logic                             touchEn_o,
  output logic                             fillEn_o,
  output logic                             fillWay_o,
  output logic [IndexBits-1:0]             fillIndex_o,
  output logic [cachePkg::WordSelBits-1:0] fillWord_o,
  output logic [cachePkg::WordSelBits-1:0] wordSel_o
);

  localparam int TagBits = 32 - IndexBits - cachePkg::OffsetBits;

  cachePkg::ctrlState_e stateQ;
  cachePkg::ctrlState_e stateD;
  cachePkg::cacheReq_t  reqQ;

  logic                             victimQ;
  logic [cachePkg::WordSelBits-1:0] beatCntQ;
  logic [IndexBits-1:0]             reqIndex;
  logic                             lookupHit;

  // fields of the held request
  assign reqIndex    = reqQ.addr[cachePkg::OffsetBits +: IndexBits];
  assign lookupTag_o = reqQ.addr[31 -: TagBits];
  assign wordSel_o   = reqQ.addr[cachePkg::OffsetBits-1 -: cachePkg::WordSelBits];

  assign lookupHit = (stateQ == cachePkg::Compare) && reqQ.valid && hit_i;

  // accept when idle, or while the previous one hits
  assign addrOk_o = valid_i && ((stateQ == cachePkg::Idle) || lookupHit);
  assign dataOk_o = lookupHit;
  assign rdData_o = rdWord_i;

  always_comb begin
    stateD = stateQ;
    case (stateQ)
      cachePkg::Idle: begin
        if (valid_i) begin
          stateD = cachePkg::Compare;
        end
      end
      cachePkg::Compare: begin
        if (!hit_i) begin
          stateD = cachePkg::Miss;
        end else if (!valid_i) begin
          stateD = cachePkg::Idle;
        end
      end
      cachePkg::Miss: begin
        stateD = cachePkg::GetData;
      end
      cachePkg::GetData: begin
        if (beat_i.valid && beat_i.last) begin
          stateD = cachePkg::Replay;
        end
      end
      cachePkg::Replay: begin
        stateD = cachePkg::Compare;
      end
      default: begin
        stateD = cachePkg::Idle;
      end
    endcase
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      stateQ   <= cachePkg::Idle;
      reqQ     <= '0;
      victimQ  <= 1'b0;
      beatCntQ <= '0;
    end else begin
      stateQ <= stateD;
      if (addrOk_o) begin
        reqQ.valid <= 1'b1;
        reqQ.addr  <= addr_i;
      end else if (lookupHit) begin
        reqQ.valid <= 1'b0;
      end
      // victim held for the whole refill
      if (stateQ == cachePkg::Compare && !hit_i) begin
        victimQ <= victimWay_i;
      end
      if (stateQ == cachePkg::Miss) begin
        beatCntQ <= '0;
      end else if (stateQ == cachePkg::GetData && beat_i.valid) begin
        beatCntQ <= beatCntQ + 1'b1;
      end
    end
  end

  // line fetch during the single Miss cycle
  assign memReq_o.valid = (stateQ == cachePkg::Miss);
  assign memReq_o.addr  = reqQ.addr & ~32'(cachePkg::LineBytes - 1);

  // new address at acceptance, held address on replay
  assign rdEn_o    = addrOk_o || (stateQ == cachePkg::Replay);
  assign rdIndex_o = (stateQ == cachePkg::Replay) ? reqIndex
                                                  : addr_i[cachePkg::OffsetBits +: IndexBits];

  assign touchEn_o   = lookupHit;
  assign fillEn_o    = (stateQ == cachePkg::GetData) && beat_i.valid && beat_i.last;
  assign fillWay_o   = (stateQ == cachePkg::Compare) ? hitWay_i : victimQ;
  assign fillIndex_o = reqIndex;
  assign fillWord_o  = beatCntQ;

endmodule

/* hdl/cacheTop.sv */
`timescale 1ns/100ps

module cacheTop #(
  parameter int IndexBits = 6
) (
  input  logic                clk,
  input  logic                rst_n,
  input  logic [31:0]         addr_i,
  input  logic                valid_i,
  output logic                addrOk_o,
  output logic                dataOk_o,
  output logic [63:0]         rdData_o,
  output busPkg::refillReq_t  memReq_o,
  input  busPkg::refillBeat_t memBeat_i
);

  localparam int TagBits = 32 - IndexBits - $clog2(cachePkg::LineBytes);

  logic                             rdEn;
  logic [IndexBits-1:0]             rdIndex;
  logic [TagBits-1:0]               lookupTag;
  logic                             touchEn;
  logic                             fillEn;
  logic                             fillWay;
  logic [IndexBits-1:0]             fillIndex;
  logic [cachePkg::WordSelBits-1:0] fillWord;
  logic [cachePkg::WordSelBits-1:0] wordSel;
  logic                             hit;
  logic                             hitWay;
  logic                             victimWay;
  logic [63:0]                      rdWord;

  cacheCtrl #(
    .IndexBits(IndexBits)
  ) ctrl_i (
    .clk        (clk),
    .rst_n      (rst_n),
    .addr_i     (addr_i),
    .valid_i    (valid_i),
    .addrOk_o   (addrOk_o),
    .dataOk_o   (dataOk_o),
    .rdData_o   (rdData_o),
    .memReq_o   (memReq_o),
    .beat_i     (memBeat_i),
    .hit_i      (hit),
    .hitWay_i   (hitWay),
    .victimWay_i(victimWay),
    .rdWord_i   (rdWord),
    .rdEn_o     (rdEn),
    .rdIndex_o  (rdIndex),
    .lookupTag_o(lookupTag),
    .touchEn_o  (touchEn),
    .fillEn_o   (fillEn),
    .fillWay_o  (fillWay),
    .fillIndex_o(fillIndex),
    .fillWord_o (fillWord),
    .wordSel_o  (wordSel)
  );

  cacheTagArray #(
    .IndexBits(IndexBits)
  ) tagArray_i (
    .clk        (clk),
    .rst_n      (rst_n),
    .rdEn_i     (rdEn),
    .rdIndex_i  (rdIndex),
    .lookupTag_i(lookupTag),
    .fillEn_i   (fillEn),
    .fillWay_i  (fillWay),
    .fillIndex_i(fillIndex),
    .touchEn_i  (touchEn),
    .hit_o      (hit),
    .hitWay_o   (hitWay),
    .victimWay_o(victimWay)
  );

  cacheDataArray #(
    .IndexBits(IndexBits)
  ) dataArray_i (
    .clk        (clk),
    .rst_n      (rst_n),
    .rdEn_i     (rdEn),
    .rdIndex_i  (rdIndex),
    .hitWay_i   (hitWay),
    .wordSel_i  (wordSel),
    .beat_i     (memBeat_i),
    .fillWay_i  (fillWay),
    .fillIndex_i(fillIndex),
    .fillWord_i (fillWord),
    .rdWord_o   (rdWord)
  );

endmodule

/* bench/axiMemModel.sv */
`timescale 1ns/100ps

module axiMemModel #(
  parameter int unsigned Seed = 43
) (
  input  logic                clk,
  input  busPkg::refillReq_t  memReq_i,
  output busPkg::refillBeat_t memBeat_o
);

  int unsigned lcgState = Seed;

  function automatic int unsigned nextRand();
    lcgState = lcgState * 32'd1664525 + 32'd1013904223;
    return lcgState >> 16;
  endfunction

  // low half is the address, high half its inverse
  function automatic logic [63:0] memWord(input logic [31:0] addr);
    return {~addr, addr};
  endfunction

  initial begin
    logic [31:0] lineAddr;
    int          beat;
    int          gap;
    memBeat_o = '0;
    forever begin
      @(posedge clk);
      if (memReq_i.valid) begin
        lineAddr = memReq_i.addr;
        beat     = 0;
        gap      = nextRand() % 4;
        // each cycle gives either a beat or an idle gap
        while (beat < cachePkg::WordsPerLine) begin
          #1;
          if (gap == 0) begin
            memBeat_o.valid = 1'b1;
            memBeat_o.last  = (beat == cachePkg::WordsPerLine - 1);
            memBeat_o.data  = memWord(lineAddr + 32'(beat * 8));
            beat++;
            gap = nextRand() % 4;
          end else begin
            memBeat_o = '0;
            gap--;
          end
          @(posedge clk);
        end
        #1;
        memBeat_o = '0;
      end
    end
  end

endmodule

/* bench/cacheTb.sv */
`timescale 1ns/100ps

module cacheTb;

  localparam int IndexBits   = 6;
  localparam int NumSets     = 1 << IndexBits;
  localparam int TagBits     = 32 - IndexBits - 5;
  localparam int AcceptLimit = 200;
  localparam int DrainLimit  = 400;

  logic                clk;
  logic                rst_n;
  logic [31:0]         reqAddr;
  logic                reqValid;
  logic                addrOk;
  logic                dataOk;
  logic [63:0]         rdData;
  busPkg::refillReq_t  memReq;
  busPkg::refillBeat_t memBeat;

  int unsigned randState   = 43;
  int unsigned cycle       = 0;
  int unsigned lastAccept  = 0;
  int          errorCount  = 0;
  int          refillCount = 0;
  int          missCount   = 0;
  int          testsPassed = 0;
  int          testsFailed = 0;
  int          testErrStart;
  bit          timedOut    = 1'b0;
  string       curTest     = "";

  // requests accepted and not yet answered, in order
  logic [31:0] pendAddrQ [$];
  bit          pendHitQ [$];
  int unsigned pendCycleQ [$];
  // line addresses the reference cache expects to be fetched
  logic [31:0] missQ [$];

  // reference cache where lru names the older way
  bit                 refValid [NumSets][2];
  logic [TagBits-1:0] refTag [NumSets][2];
  bit                 refLru [NumSets];

  cacheTop #(
    .IndexBits(IndexBits)
  ) dut_i (
    .clk      (clk),
    .rst_n    (rst_n),
    .addr_i   (reqAddr),
    .valid_i  (reqValid),
    .addrOk_o (addrOk),
    .dataOk_o (dataOk),
    .rdData_o (rdData),
    .memReq_o (memReq),
    .memBeat_i(memBeat)
  );

  axiMemModel #(
    .Seed(43)
  ) memModel_i (
    .clk      (clk),
    .memReq_i (memReq),
    .memBeat_o(memBeat)
  );

  always #4 clk = ~clk;

  always @(posedge clk) begin
    cycle <= cycle + 1;
  end

  function automatic int unsigned nextRand();
    randState = randState * 32'd1103515245 + 32'd12345;
    return randState >> 8;
  endfunction

  function automatic logic [63:0] expectedWord(input logic [31:0] addr);
    logic [31:0] wordAddr;
    wordAddr = {addr[31:3], 3'b000};
    return {~wordAddr, wordAddr};
  endfunction

  function automatic logic [31:0] makeAddr(input int unsigned tag, input int unsigned set,
                                           input int unsigned offset);
    return {tag[TagBits-1:0], set[IndexBits-1:0], offset[4:0]};
  endfunction

  // updates the reference cache and tells whether the access hits
  function automatic bit predictHit(input logic [31:0] addr);
    int                 set;
    int                 way;
    logic [TagBits-1:0] tag;
    set = addr[IndexBits+4:5];
    tag = addr[31:IndexBits+5];
    way = -1;
    for (int w = 0; w < 2; w++) begin
      if (refValid[set][w] && refTag[set][w] == tag) begin
        way = w;
      end
    end
    if (way >= 0) begin
      refLru[set] = (way == 0);
      return 1'b1;
    end
    if (!refValid[set][0]) begin
      way = 0;
    end else if (!refValid[set][1]) begin
      way = 1;
    end else begin
      way = refLru[set];
    end
    refValid[set][way] = 1'b1;
    refTag[set][way]   = tag;
    refLru[set]        = (way == 0);
    return 1'b0;
  endfunction

  task automatic checkValue(input string name, input logic [63:0] expected,
                            input logic [63:0] actual);
    if (actual !== expected) begin
      errorCount++;
      $display("mismatch %s: expected %h, actual %h", name, expected, actual);
    end
  endtask

  // presents one request and returns in the cycle after it was accepted
  task automatic issue(input logic [31:0] addr);
    int waited;
    bit accepted;
    bit hit;
    if (timedOut) begin
      return;
    end
    reqAddr  = addr;
    reqValid = 1'b1;
    waited   = 0;
    accepted = 1'b0;
    while (!accepted && waited < AcceptLimit) begin
      @(posedge clk);
      accepted = addrOk;
      waited++;
    end
    if (!accepted) begin
      $display("timeout: request %h was not accepted within %0d cycles", addr, AcceptLimit);
      errorCount++;
      timedOut = 1'b1;
      reqValid = 1'b0;
      return;
    end
    hit = predictHit(addr);
    if (!hit) begin
      missCount++;
      missQ.push_back(addr & ~32'h1F);
    end
    pendAddrQ.push_back(addr);
    pendHitQ.push_back(hit);
    pendCycleQ.push_back(cycle);
    lastAccept = cycle;
    #1;
    reqValid = 1'b0;
  endtask

  task automatic drain();
    int waited;
    reqValid = 1'b0;
    waited   = 0;
    while (!timedOut && pendAddrQ.size() > 0 && waited < DrainLimit) begin
      @(negedge clk);
      waited++;
    end
    if (!timedOut && pendAddrQ.size() > 0) begin
      $display("timeout: %0d responses still missing after %0d cycles",
               pendAddrQ.size(), DrainLimit);
      errorCount++;
      timedOut = 1'b1;
    end
    @(posedge clk);
    #1;
  endtask

  task automatic startTest(input string name);
    curTest      = name;
    testErrStart = errorCount;
  endtask

  task automatic finishTest();
    if (errorCount == testErrStart) begin
      testsPassed++;
      $display("test %-12s ok", curTest);
    end else begin
      testsFailed++;
      $display("test %-12s failed with %0d errors", curTest, errorCount - testErrStart);
    end
  endtask

  // every response and every line fetch is checked here
  always @(posedge clk) begin
    logic [31:0] addr;
    bit          hit;
    int unsigned accCycle;
    if (rst_n && dataOk) begin
      if (pendAddrQ.size() == 0) begin
        errorCount++;
        $display("%s: response without an outstanding request", curTest);
      end else begin
        addr     = pendAddrQ.pop_front();
        hit      = pendHitQ.pop_front();
        accCycle = pendCycleQ.pop_front();
        checkValue(curTest, expectedWord(addr), rdData);
        if (hit) begin
          checkValue({curTest, " hit latency"}, accCycle + 1, cycle);
        end
      end
    end
    if (rst_n && memReq.valid) begin
      refillCount++;
      if (missQ.size() == 0) begin
        errorCount++;
        $display("%s: refill request for %h where no miss was expected", curTest, memReq.addr);
      end else begin
        checkValue({curTest, " refill address"}, missQ.pop_front(), memReq.addr);
      end
    end
  end

  initial begin
    int          startRefills;
    int          startMisses;
    int unsigned prevAccept;
    int unsigned tag;
    int unsigned set;
    int unsigned offset;
    logic [31:0] base;
    clk      = 1'b0;
    rst_n    = 1'b0;
    reqAddr  = '0;
    reqValid = 1'b0;
    repeat (3) @(posedge clk);
    #1;
    rst_n = 1'b1;

    startTest("reset");
    checkValue("reset addrOk", 0, addrOk);
    checkValue("reset dataOk", 0, dataOk);
    checkValue("reset refill valid", 0, memReq.valid);
    issue(32'h0000_1234);
    drain();
    checkValue("reset refill count", 1, refillCount);
    finishTest();

    // all four word positions of a fresh line
    startTest("read data");
    startRefills = refillCount;
    base = 32'h0000_2A00;
    issue(base + 32'h1B);
    issue(base + 32'h05);
    issue(base + 32'h10);
    issue(base + 32'h0F);
    drain();
    checkValue("read data refill count", 1, refillCount - startRefills);
    finishTest();

    startTest("hit timing");
    startRefills = refillCount;
    issue(base);
    for (int w = 1; w < 4; w++) begin
      prevAccept = lastAccept;
      issue(base + 32'(8 * w));
      checkValue("hit timing back-to-back", prevAccept + 1, lastAccept);
    end
    drain();
    checkValue("hit timing refill count", 0, refillCount - startRefills);
    finishTest();

    // accesses A B A C B in one set and C takes B's way
    startTest("replacement");
    startRefills = refillCount;
    issue(makeAddr(5, 20, 8));
    issue(makeAddr(9, 20, 16));
    issue(makeAddr(5, 20, 0));
    issue(makeAddr(13, 20, 24));
    issue(makeAddr(9, 20, 8));
    drain();
    checkValue("replacement refill count", 4, refillCount - startRefills);
    finishTest();

    startTest("random");
    startRefills = refillCount;
    startMisses  = missCount;
    for (int n = 0; n < 300; n++) begin
      tag    = 100 + nextRand() % 4;
      set    = 40 + nextRand() % 3;
      offset = nextRand() % 32;
      issue(makeAddr(tag, set, offset));
      if (nextRand() % 4 == 0) begin
        @(posedge clk);
        #1;
      end
    end
    drain();
    checkValue("random refill count", missCount - startMisses, refillCount - startRefills);
    finishTest();

    $display("tests: %0d passed, %0d failed, %0d errors", testsPassed, testsFailed, errorCount);
    if (errorCount == 0 && !timedOut) begin
      $display("TEST PASS");
    end else begin
      $display("TEST FAIL");
    end
    $finish;
  end

endmodule

/* tb.f */
hdl/cachePkg.sv
hdl/busPkg.sv
hdl/cacheTagArray.sv
hdl/cacheDataArray.sv
hdl/cacheCtrl.sv
hdl/cacheTop.sv
bench/axiMemModel.sv
bench/cacheTb.sv
